//--- all.f
design/fetch_pkg.sv
design/line_fill.sv
design/fetch_line_buffer.sv
design/fetch_ctrl.sv
design/fetch_queue.sv
design/fetch_top.sv
test/fetch_chk.sv
test/fetch_tb.sv

//--- design/fetch_ctrl.sv
module fetch_ctrl
    import fetch_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   redirect_valid_i,
    input   logic   [XLEN-1:0]      redirect_pc_i,

    input   logic                   hit_i,
    input   logic   [XLEN-1:0]      hit_word_i,
    output  logic   [XLEN-1:0]      lookup_pc_o,

    output  logic                   fill_start_o,
    output  logic   [XLEN-1:0]      fill_addr_o,
    input   logic                   fill_busy_i,

    input   logic                   q_full_i,
    output  logic                   q_write_o,
    output  logic   [ENTRY_BITS-1:0] q_entry_o,
    output  logic                   q_flush_o
);

    logic   [XLEN-1:0]  pc_q;
    logic               miss_pending;
    logic               need_fill;

    // miss with nothing in flight, skipped in a redirect cycle
    assign need_fill = !hit_i && !fill_busy_i && !miss_pending && !redirect_valid_i;

    // enqueue straight from the buffer on a hit
    assign q_write_o = hit_i && !q_full_i && !redirect_valid_i;
    assign q_entry_o = {pc_q, hit_word_i};
    assign q_flush_o = redirect_valid_i;

    assign lookup_pc_o = pc_q;

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (q_write_o) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    // one start pulse per miss
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_start_o <= 1'b0;
            miss_pending <= 1'b0;
        end else begin
            fill_start_o <= need_fill;
            if (need_fill) begin
                miss_pending <= 1'b1;
            end else if (fill_busy_i) begin
                // line_fill has taken the start
                miss_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (need_fill) begin
            fill_addr_o <= pc_q;
        end
    end

endmodule : fetch_ctrl

//--- design/fetch_line_buffer.sv
module fetch_line_buffer
    import fetch_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   fill_done_i,
    input   logic   [XLEN-1:0]      fill_addr_i,
    input   logic   [LINE_BITS-1:0] fill_line_i,

    input   logic   [XLEN-1:0]      lookup_pc_i,
    output  logic                   hit_o,
    output  logic   [XLEN-1:0]      hit_word_o
);

    logic                               valid_q;
    logic   [XLEN-LINE_OFFSET_BITS-1:0] tag_q;
    logic   [LINE_BITS-1:0]             line_q;
    logic   [WORD_SEL_BITS-1:0]         word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_done_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_q  <= fill_addr_i[XLEN-1:LINE_OFFSET_BITS];
            line_q <= fill_line_i;
        end
    end

    // word index sits just above the two byte bits
    assign word_sel   = lookup_pc_i[2 +: WORD_SEL_BITS];
    assign hit_o      = valid_q && (lookup_pc_i[XLEN-1:LINE_OFFSET_BITS] == tag_q);
    assign hit_word_o = line_q[word_sel * XLEN +: XLEN];

endmodule : fetch_line_buffer

//--- design/fetch_pkg.sv
package fetch_pkg;

    // address and instruction width
    localparam int XLEN = 32;

    // line and memory beat geometry
    localparam int LINE_BITS        = 256;
    localparam int BEAT_BITS        = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int BEAT_CNT_BITS    = $clog2(BEATS_PER_LINE);

    // byte offset inside a line, tag sits above it
    localparam int LINE_OFFSET_BITS = 5;
    // word index inside a line, just above the byte-in-word bits
    localparam int WORD_SEL_BITS    = 3;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'haaaaa000;

    // instruction queue, entry is pc then instruction
    localparam int QUEUE_DEPTH      = 8;
    localparam int QUEUE_PTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int ENTRY_BITS       = 2 * XLEN;

endpackage : fetch_pkg

//--- design/fetch_queue.sv
module fetch_queue
    import fetch_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   flush_i,
    input   logic                   write_i,
    input   logic   [ENTRY_BITS-1:0] entry_i,
    output  logic                   full_o,

    output  logic                   out_valid_o,
    output  logic   [XLEN-1:0]      out_pc_o,
    output  logic   [XLEN-1:0]      out_data_o,
    input   logic                   out_ready_i
);

    logic   [ENTRY_BITS-1:0]        mem [QUEUE_DEPTH];
    logic   [QUEUE_PTR_BITS-1:0]    wr_ptr;
    logic   [QUEUE_PTR_BITS-1:0]    rd_ptr;
    logic   [QUEUE_PTR_BITS:0]      count;
    logic                           push;
    logic                           pop;

    assign full_o      = (count == (QUEUE_PTR_BITS + 1)'(QUEUE_DEPTH));
    assign out_valid_o = (count != '0);
    assign push        = write_i && !full_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush_i) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    // head split into pc and instruction
    assign out_pc_o   = mem[rd_ptr][ENTRY_BITS-1:XLEN];
    assign out_data_o = mem[rd_ptr][XLEN-1:0];

endmodule : fetch_queue

//--- design/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    output  logic   [XLEN-1:0]      bmem_addr_o,
    output  logic                   bmem_read_o,
    input   logic                   bmem_ready_i,
    input   logic   [XLEN-1:0]      bmem_raddr_i,
    input   logic   [BEAT_BITS-1:0] bmem_rdata_i,
    input   logic                   bmem_rvalid_i,

    input   logic                   redirect_valid_i,
    input   logic   [XLEN-1:0]      redirect_pc_i,

    output  logic                   instr_valid_o,
    output  logic   [XLEN-1:0]      instr_pc_o,
    output  logic   [XLEN-1:0]      instr_data_o,
    input   logic                   instr_ready_i
);

    logic                   hit;
    logic   [XLEN-1:0]      hit_word;
    logic   [XLEN-1:0]      lookup_pc;
    logic                   fill_start;
    logic   [XLEN-1:0]      fill_addr;
    logic                   fill_busy;
    logic                   fill_done;
    logic   [LINE_BITS-1:0] fill_line;
    logic   [XLEN-1:0]      fill_line_addr;
    logic                   q_full;
    logic                   q_write;
    logic   [ENTRY_BITS-1:0] q_entry;
    logic                   q_flush;

    fetch_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .redirect_valid_i   (redirect_valid_i),
        .redirect_pc_i      (redirect_pc_i),
        .hit_i              (hit),
        .hit_word_i         (hit_word),
        .lookup_pc_o        (lookup_pc),
        .fill_start_o       (fill_start),
        .fill_addr_o        (fill_addr),
        .fill_busy_i        (fill_busy),
        .q_full_i           (q_full),
        .q_write_o          (q_write),
        .q_entry_o          (q_entry),
        .q_flush_o          (q_flush)
    );

    // steers the hit/miss decisions of the controller
    fetch_line_buffer u_line_buf (
        .clk                (clk),
        .rst                (rst),
        .fill_done_i        (fill_done),
        .fill_addr_i        (fill_line_addr),
        .fill_line_i        (fill_line),
        .lookup_pc_i        (lookup_pc),
        .hit_o              (hit),
        .hit_word_o         (hit_word)
    );

    line_fill u_fill (
        .clk                (clk),
        .rst                (rst),
        .start_i            (fill_start),
        .addr_i             (fill_addr),
        .busy_o             (fill_busy),
        .done_o             (fill_done),
        .line_o             (fill_line),
        .line_addr_o        (fill_line_addr),
        .bmem_addr_o        (bmem_addr_o),
        .bmem_read_o        (bmem_read_o),
        .bmem_ready_i       (bmem_ready_i),
        .bmem_raddr_i       (bmem_raddr_i),
        .bmem_rdata_i       (bmem_rdata_i),
        .bmem_rvalid_i      (bmem_rvalid_i)
    );

    fetch_queue u_queue (
        .clk                (clk),
        .rst                (rst),
        .flush_i            (q_flush),
        .write_i            (q_write),
        .entry_i            (q_entry),
        .full_o             (q_full),
        .out_valid_o        (instr_valid_o),
        .out_pc_o           (instr_pc_o),
        .out_data_o         (instr_data_o),
        .out_ready_i        (instr_ready_i)
    );

endmodule : fetch_top

//--- design/line_fill.sv
module line_fill
    import fetch_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic                   start_i,
    input   logic   [XLEN-1:0]      addr_i,
    output  logic                   busy_o,
    output  logic                   done_o,
    output  logic   [LINE_BITS-1:0] line_o,
    output  logic   [XLEN-1:0]      line_addr_o,

    output  logic   [XLEN-1:0]      bmem_addr_o,
    output  logic                   bmem_read_o,
    input   logic                   bmem_ready_i,
    input   logic   [XLEN-1:0]      bmem_raddr_i,
    input   logic   [BEAT_BITS-1:0] bmem_rdata_i,
    input   logic                   bmem_rvalid_i
);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_COLLECT
    } fill_state_t;

    fill_state_t                state;
    logic   [BEAT_CNT_BITS-1:0] beat_cnt;
    logic   [LINE_BITS-1:0]     line_q;
    logic                       done_q;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= FILL_IDLE;
            bmem_read_o <= 1'b0;
            beat_cnt    <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                FILL_IDLE: begin
                    if (start_i) begin
                        bmem_read_o <= 1'b1;
                        state       <= FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    // read stays up until memory takes it
                    if (bmem_ready_i) begin
                        bmem_read_o <= 1'b0;
                        beat_cnt    <= '0;
                        state       <= FILL_COLLECT;
                    end
                end
                FILL_COLLECT: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == BEAT_CNT_BITS'(BEATS_PER_LINE - 1)) begin
                            done_q <= 1'b1;
                            state  <= FILL_IDLE;
                        end
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // request address, line aligned
    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && start_i) begin
            bmem_addr_o <= {addr_i[XLEN-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
    end

    // beats shift in from the top, first beat ends at the bottom
    always_ff @(posedge clk) begin
        if (state == FILL_COLLECT && bmem_rvalid_i) begin
            line_q      <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
            line_addr_o <= bmem_raddr_i;
        end
    end

    // busy also covers the done cycle, buffer loads at its end
    assign busy_o = (state != FILL_IDLE) || done_q;
    assign done_o = done_q;
    assign line_o = line_q;

endmodule : line_fill

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module fetch_tb -o fetch_sim

# the grep below decides the result, so a nonzero exit here must not stop the script
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- test/fetch_chk.sv
module fetch_chk
    import fetch_pkg::*;
(
    input   logic               clk,
    input   logic               rst,
    input   logic   [XLEN-1:0]  bmem_addr_o,
    input   logic               bmem_read_o,
    input   logic               bmem_ready_i,
    input   logic               bmem_rvalid_i,
    input   logic               redirect_valid_i,
    input   logic               instr_valid_o,
    input   logic   [XLEN-1:0]  instr_pc_o,
    input   logic   [XLEN-1:0]  instr_data_o,
    input   logic               instr_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic   [2:0]   beats_left;
    logic           assert_failed = 1'b0;

    // beats still owed by memory for the accepted line
    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (bmem_read_o && bmem_ready_i) begin
            beats_left <= 3'(BEATS_PER_LINE);
        end else if (bmem_rvalid_i && beats_left != '0) begin
            beats_left <= beats_left - 3'd1;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i |=> bmem_read_o && $stable(bmem_addr_o))
        else begin
            assert_failed = 1'b1;
            $error("read request dropped or address changed before acceptance");
        end

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        beats_left != '0 |-> !bmem_read_o)
        else begin
            assert_failed = 1'b1;
            $error("new read request while beats are outstanding");
        end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        instr_valid_o && !instr_ready_i && !redirect_valid_i
        |=> instr_valid_o && $stable(instr_pc_o) && $stable(instr_data_o))
        else begin
            assert_failed = 1'b1;
            $error("output changed while stalled");
        end

endmodule : fetch_chk

//--- test/fetch_tb.sv
module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD          = 40;
    localparam int MAX_TRANSFERS       = 2000;
    localparam int CYCLES_PER_TRANSFER = 40;
    localparam logic [31:0] INSTR_KEY  = 32'h13579bdf;

    logic                   clk;
    logic                   rst;
    logic   [XLEN-1:0]      bmem_addr_o;
    logic                   bmem_read_o;
    logic                   bmem_ready_i;
    logic   [XLEN-1:0]      bmem_raddr_i;
    logic   [BEAT_BITS-1:0] bmem_rdata_i;
    logic                   bmem_rvalid_i;
    logic                   redirect_valid_i;
    logic   [XLEN-1:0]      redirect_pc_i;
    logic                   instr_valid_o;
    logic   [XLEN-1:0]      instr_pc_o;
    logic   [XLEN-1:0]      instr_data_o;
    logic                   instr_ready_i;

    logic   [31:0]          lfsr = 32'hdf1ba191;
    logic   [XLEN-1:0]      exp_pc = RESET_PC;
    logic   [ENTRY_BITS-1:0] exp_entry;
    int unsigned            xfer_count = 0;
    logic                   slow_mem = 1'b0;

    fetch_top DUT (.*);

    bind fetch_top fetch_chk u_chk (
        .clk                (clk),
        .rst                (rst),
        .bmem_addr_o        (bmem_addr_o),
        .bmem_read_o        (bmem_read_o),
        .bmem_ready_i       (bmem_ready_i),
        .bmem_rvalid_i      (bmem_rvalid_i),
        .redirect_valid_i   (redirect_valid_i),
        .instr_valid_o      (instr_valid_o),
        .instr_pc_o         (instr_pc_o),
        .instr_data_o       (instr_data_o),
        .instr_ready_i      (instr_ready_i)
    );

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return r;
    endfunction

    // memory content rule
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ INSTR_KEY;
    endfunction

    // expected pc/instruction pair for a given fetch pc
    function automatic logic [ENTRY_BITS-1:0] expected_entry(input logic [31:0] pc);
        return {pc, mem_word(pc)};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %0d ns: %s got %h expected %h", $time, what, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic run_transfers(input int unsigned n, input bit random_ready);
        int unsigned target;
        target = xfer_count + n;
        while (xfer_count < target) begin
            @(negedge clk);
            instr_ready_i = random_ready ? 1'(rand_bits(1)) : 1'b1;
        end
    endtask

    task automatic hold_ready_low(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            instr_ready_i = 1'b0;
        end
    endtask

    task automatic redirect_to(input logic [31:0] target);
        @(negedge clk);
        instr_ready_i    = 1'b0;
        redirect_valid_i = 1'b1;
        redirect_pc_i    = target;
        @(negedge clk);
        redirect_valid_i = 1'b0;
    endtask

    task automatic wait_for_fill();
        do begin
            @(negedge clk);
        end while (bmem_read_o !== 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // burst memory accepts after a random delay and returns four beats
    initial begin : memory_model
        logic [31:0] line_addr;
        int unsigned wait_cycles;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (!rst && bmem_read_o === 1'b1) begin
                line_addr   = bmem_addr_o;
                wait_cycles = slow_mem ? rand_bits(5) : rand_bits(2);
                repeat (wait_cycles) @(negedge clk);
                bmem_ready_i = 1'b1;
                @(negedge clk);
                bmem_ready_i = 1'b0;
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    wait_cycles = slow_mem ? rand_bits(3) : rand_bits(1);
                    repeat (wait_cycles) @(negedge clk);
                    bmem_rvalid_i = 1'b1;
                    bmem_raddr_i  = line_addr;
                    bmem_rdata_i  = {mem_word(line_addr + 32'(8 * b + 4)),
                                     mem_word(line_addr + 32'(8 * b))};
                    @(negedge clk);
                    bmem_rvalid_i = 1'b0;
                end
            end
        end
    end

    // expected pc restarts at reset and at every redirect
    always @(posedge clk) begin
        if (rst) begin
            exp_pc = RESET_PC;
        end else if (redirect_valid_i) begin
            exp_pc = redirect_pc_i;
        end else if (instr_valid_o && instr_ready_i) begin
            exp_entry = expected_entry(exp_pc);
            check_value("pc", instr_pc_o, exp_entry[ENTRY_BITS-1:XLEN]);
            check_value("instr", instr_data_o, exp_entry[XLEN-1:0]);
            exp_pc     = exp_pc + 32'd4;
            xfer_count = xfer_count + 1;
        end
    end

    always @(posedge clk) begin
        if (DUT.u_chk.assert_failed) begin
            $display("a bound protocol assertion fired at %0d ns", $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "protocol assertion");
        end
    end

    initial begin : watchdog
        #(MAX_TRANSFERS * CYCLES_PER_TRANSFER * CLK_PERIOD);
        $display("timeout: the output stream stalled, only %0d transfers seen", xfer_count);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog");
    end

    initial begin : stimulus
        logic [31:0] tgt;
        rst              = 1'b1;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        instr_ready_i    = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // straight sequential stream across several lines
        run_transfers(40, 1'b0);
        run_transfers(200, 1'b1);

        // redirects near the current pc and far away with the queue loaded
        for (int i = 0; i < 20; i++) begin
            hold_ready_low(rand_bits(4));
            tgt = (rand_bits(1) != 0) ? exp_pc + (rand_bits(4) << 2) : rand_bits(30) << 2;
            redirect_to(tgt);
            run_transfers(10 + rand_bits(4), 1'b1);
        end

        // second redirect lands while the first miss is being filled
        for (int i = 0; i < 10; i++) begin
            redirect_to(32'h40000000 + 32'(i) * 32'h1000 + (rand_bits(3) << 2));
            wait_for_fill();
            repeat (rand_bits(3)) @(negedge clk);
            redirect_to(32'h60000000 + 32'(i) * 32'h1000 + (rand_bits(3) << 2));
            run_transfers(12, 1'b1);
        end

        // slow memory and a full queue
        slow_mem = 1'b1;
        for (int i = 0; i < 5; i++) begin
            hold_ready_low(60);
            run_transfers(30, 1'b1);
        end
        slow_mem = 1'b0;
        run_transfers(8, 1'b0);

        if (!DUT.u_chk.assert_failed) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : fetch_tb
